//--- dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

//////////////////////////////////////////////////
// address split
//////////////////////////////////////////////////
`define DC_TAG_W     20
`define DC_INDEX_W   8
`define DC_OFFSET_W  4   // byte offset in a line

//////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////
`define DC_SETS      256 // 2**DC_INDEX_W
`define DC_WAYS      2
`define DC_WORDS     4   // words per line
`define DC_WORD_W    32
`define DC_LINE_W    128 // one memory beat

`endif

//--- dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;  // [3:2] picks the word
    } paddr_t;

    // one line, seen as a memory beat or as words
    typedef union packed {
        logic [`DC_LINE_W-1:0]                raw;
        logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] words;  // word 0 at lsb
    } cache_line_u;

    typedef struct packed {
        logic                  rvalid;
        logic                  wvalid;
        paddr_t                addr;
        logic [3:0]            wsel;    // byte enables
        logic [`DC_WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tagv_t;

    typedef enum logic [1:0] {LOOKUP, WRITEBACK, REFILL} ctrl_state_e;

endpackage

//--- dcache_tag_store.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] rd_index_i,
    input  cpu_req_t               s2_i,
    input  logic                   fill_i,
    input  logic                   store_hit_i,
    output logic                   hit_way0_o,
    output logic                   hit_way1_o,
    output logic                   victim_way_o,
    output logic                   victim_dirty_o,
    output logic [`DC_TAG_W-1:0]   victim_tag_o
);
    logic [`DC_INDEX_W-1:0]               idx;
    logic                                 req_v;
    logic                                 victim;
    logic [`DC_WAYS-1:0]                  hit;
    tagv_t                                tv_s2 [`DC_WAYS];
    logic [`DC_SETS-1:0]                  lru;    // 1: way 1 is the victim
    logic [`DC_SETS-1:0][`DC_WAYS-1:0]    dirty;
    logic                                 fwd_valid;
    logic                                 fwd_way;
    logic [`DC_INDEX_W-1:0]               fwd_index;
    logic [`DC_TAG_W-1:0]                 fwd_tag;

    assign idx    = s2_i.addr.index;
    assign req_v  = s2_i.rvalid | s2_i.wvalid;
    assign victim = lru[idx];

    //////////////////////////////////////////////////
    // tag arrays, one per way
    //////////////////////////////////////////////////
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        tagv_t mem [`DC_SETS];
        tagv_t q;

        always_ff @(posedge clk) begin
            if (!rst) begin
                for (int i = 0; i < `DC_SETS; i++) begin
                    mem[i].valid <= 1'b0;
                end
            end else if (fill_i && victim == 1'(w)) begin
                mem[idx] <= '{valid: 1'b1, tag: s2_i.addr.tag};
            end
            q <= mem[rd_index_i];
        end

        // tag filled last cycle is not in q yet
        assign tv_s2[w] = (fwd_valid && fwd_way == 1'(w) && fwd_index == idx) ?
                          '{valid: 1'b1, tag: fwd_tag} : q;
        assign hit[w]   = req_v && tv_s2[w].valid && (tv_s2[w].tag == s2_i.addr.tag);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= fill_i;
        end
        fwd_way   <= victim;
        fwd_index <= idx;
        fwd_tag   <= s2_i.addr.tag;
    end

    //////////////////////////////////////////////////
    // dirty and LRU bits
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            dirty <= '0;
            lru   <= '0;
        end else if (fill_i) begin
            dirty[idx][victim] <= s2_i.wvalid;  // store miss leaves it dirty
            lru[idx]           <= ~victim;
        end else if (|hit) begin
            lru[idx] <= hit[0];                 // other way goes next
            if (store_hit_i) begin
                dirty[idx][hit[1]] <= 1'b1;
            end
        end
    end

    assign hit_way0_o     = hit[0];
    assign hit_way1_o     = hit[1];
    assign victim_way_o   = victim;
    assign victim_dirty_o = dirty[idx][victim];
    assign victim_tag_o   = tv_s2[victim].tag;

    // a tag lives in one way only, forwarding included
    assert property (@(posedge clk) disable iff (!rst) !(hit[0] && hit[1]));

endmodule

//--- dcache_data_store.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_data_store import dcache_pkg::*; (
    input  logic                   clk,
    input  logic [`DC_INDEX_W-1:0] rd_index_i,
    input  cpu_req_t               s2_i,
    input  logic                   hit_way1_i,
    input  logic                   victim_way_i,
    input  logic                   fill_i,
    input  logic                   store_hit_i,
    input  cache_line_u            ret_data_i,
    output logic [`DC_WORD_W-1:0]  hit_word_o,
    output cache_line_u            victim_line_o
);
    logic [1:0]               word_sel;
    cache_line_u              line_s2 [`DC_WAYS];
    cache_line_u              base_line;
    cache_line_u              wr_line;
    logic [`DC_WORD_W-1:0]    wmask;
    logic [4*`DC_WORDS-1:0]   byte_en;
    logic                     wr_en;
    logic                     wr_way;
    logic                     fwd_valid;
    logic                     fwd_way;
    logic [`DC_INDEX_W-1:0]   fwd_index;
    cache_line_u              fwd_line;

    assign word_sel = s2_i.addr.offset[3:2];
    assign wr_en    = fill_i | store_hit_i;
    assign wr_way   = fill_i ? victim_way_i : hit_way1_i;
    assign wmask    = {{8{s2_i.wsel[3]}}, {8{s2_i.wsel[2]}}, {8{s2_i.wsel[1]}}, {8{s2_i.wsel[0]}}};

    //////////////////////////////////////////////////
    // line merge
    //////////////////////////////////////////////////
    assign base_line = fill_i ? ret_data_i : line_s2[hit_way1_i];

    always_comb begin
        wr_line = base_line;
        if (s2_i.wvalid) begin
            wr_line.words[word_sel] = (s2_i.wdata & wmask) |
                                      (base_line.words[word_sel] & ~wmask);
        end
    end

    // refill writes the whole line, store hit only its bytes
    assign byte_en = fill_i ? '1 :
                     {{(4*`DC_WORDS-4){1'b0}}, s2_i.wsel} << {word_sel, 2'b00};

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic [`DC_LINE_W-1:0] mem [`DC_SETS];
        cache_line_u           q;

        always_ff @(posedge clk) begin
            if (wr_en && wr_way == 1'(w)) begin
                for (int b = 0; b < 4*`DC_WORDS; b++) begin
                    if (byte_en[b]) begin
                        mem[s2_i.addr.index][8*b +: 8] <= wr_line.raw[8*b +: 8];
                    end
                end
            end
            q.raw <= mem[rd_index_i];
        end

        assign line_s2[w] = (fwd_valid && fwd_way == 1'(w) && fwd_index == s2_i.addr.index) ?
                            fwd_line : q;
    end

    // last write, for the request that read around it
    always_ff @(posedge clk) begin
        fwd_valid <= wr_en;
        fwd_way   <= wr_way;
        fwd_index <= s2_i.addr.index;
        fwd_line  <= wr_line;
    end

    assign hit_word_o    = line_s2[hit_way1_i].words[word_sel];
    assign victim_line_o = line_s2[victim_way_i];

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_req_t              s2_i,
    input  logic                  hit_way0_i,
    input  logic                  hit_way1_i,
    input  logic                  victim_dirty_i,
    input  logic [`DC_TAG_W-1:0]  victim_tag_i,
    input  logic [`DC_WORD_W-1:0] hit_word_i,
    input  cache_line_u           victim_line_i,
    input  logic                  ret_valid_i,
    input  cache_line_u           ret_data_i,
    input  logic                  wr_rdy_i,
    output logic                  stall_o,
    output logic                  data_ok_o,
    output logic [`DC_WORD_W-1:0] rdata_o,
    output logic                  hit_o,
    output logic                  fill_o,
    output logic                  store_hit_o,
    output logic                  rd_req_o,
    output paddr_t                rd_addr_o,
    output logic                  wr_req_o,
    output paddr_t                wr_addr_o,
    output cache_line_u           wr_data_o
);
    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        req_v;
    logic        hit;
    logic        miss;
    logic        in_lookup;
    logic        in_refill;

    assign req_v     = s2_i.rvalid | s2_i.wvalid;
    assign hit       = hit_way0_i | hit_way1_i;
    assign miss      = req_v & ~hit;
    assign in_lookup = (state == LOOKUP);
    assign in_refill = (state == REFILL);

    //////////////////////////////////////////////////
    // miss FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (miss) begin
                    state_nxt = victim_dirty_i ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: begin
                if (wr_rdy_i) begin
                    state_nxt = REFILL;  // victim written, fetch next
                end
            end
            REFILL: begin
                if (ret_valid_i) begin
                    state_nxt = LOOKUP;
                end
            end
            default: state_nxt = LOOKUP;
        endcase
    end

    //////////////////////////////////////////////////
    // CPU side
    //////////////////////////////////////////////////
    assign stall_o     = (in_lookup & miss) | (state == WRITEBACK) | (in_refill & ~ret_valid_i);
    assign hit_o       = in_lookup & req_v & hit;
    assign store_hit_o = in_lookup & s2_i.wvalid & hit;
    assign fill_o      = in_refill & ret_valid_i;
    assign data_ok_o   = s2_i.rvalid & ((in_lookup & hit) | fill_o);
    assign rdata_o     = in_refill ? ret_data_i.words[s2_i.addr.offset[3:2]] : hit_word_i;

    // memory side, line aligned
    assign rd_req_o  = in_refill & ~ret_valid_i;
    assign rd_addr_o = '{tag: s2_i.addr.tag, index: s2_i.addr.index, offset: '0};
    assign wr_req_o  = (state == WRITEBACK);
    assign wr_addr_o = '{tag: victim_tag_i, index: s2_i.addr.index, offset: '0};
    assign wr_data_o = victim_line_i;

    // one transfer at a time on the memory side
    assert property (@(posedge clk) disable iff (!rst) !(rd_req_o && wr_req_o));

    // victim stays put while memory holds off
    assert property (@(posedge clk) disable iff (!rst)
        wr_req_o && !wr_rdy_i |=> wr_req_o && $stable(wr_data_o) && $stable(wr_addr_o));

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_req_t              req_i,
    input  logic                  ret_valid_i,
    input  cache_line_u           ret_data_i,
    input  logic                  wr_rdy_i,
    output logic                  stall_o,
    output logic                  data_ok_o,
    output logic [`DC_WORD_W-1:0] rdata_o,
    output logic                  hit_o,
    output logic                  rd_req_o,
    output paddr_t                rd_addr_o,
    output logic                  wr_req_o,
    output paddr_t                wr_addr_o,
    output cache_line_u           wr_data_o
);
    cpu_req_t               s2;
    logic [`DC_INDEX_W-1:0] rd_index;
    logic                   hit_way0;
    logic                   hit_way1;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [`DC_TAG_W-1:0]   victim_tag;
    logic [`DC_WORD_W-1:0]  hit_word;
    cache_line_u            victim_line;
    logic                   fill;
    logic                   store_hit;

    //////////////////////////////////////////////////
    // stage 2 request register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            s2.rvalid <= 1'b0;
            s2.wvalid <= 1'b0;
            s2.addr   <= '0;
        end else if (!stall_o) begin
            s2 <= req_i;
        end
    end

    // replay the stalled set so the stores keep presenting it
    assign rd_index = stall_o ? s2.addr.index : req_i.addr.index;

    dcache_tag_store tags0 (
        .clk(clk), .rst(rst),
        .rd_index_i(rd_index), .s2_i(s2),
        .fill_i(fill), .store_hit_i(store_hit),
        .hit_way0_o(hit_way0), .hit_way1_o(hit_way1),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
        .victim_tag_o(victim_tag)
    );

    dcache_data_store data0 (
        .clk(clk),
        .rd_index_i(rd_index), .s2_i(s2),
        .hit_way1_i(hit_way1), .victim_way_i(victim_way),
        .fill_i(fill), .store_hit_i(store_hit),
        .ret_data_i(ret_data_i),
        .hit_word_o(hit_word), .victim_line_o(victim_line)
    );

    dcache_ctrl ctrl0 (
        .clk(clk), .rst(rst), .s2_i(s2),
        .hit_way0_i(hit_way0), .hit_way1_i(hit_way1),
        .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
        .hit_word_i(hit_word), .victim_line_i(victim_line),
        .ret_valid_i(ret_valid_i), .ret_data_i(ret_data_i), .wr_rdy_i(wr_rdy_i),
        .stall_o(stall_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o), .hit_o(hit_o),
        .fill_o(fill), .store_hit_o(store_hit),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o)
    );

endmodule

//--- tb_dcache_checker.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache_checker import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    req_i,
    input  logic [95:0] name_i,
    input  logic [31:0] exp_i,
    input  logic        fetch_i,
    input  logic        chk_i,
    input  logic        stall_i,
    input  logic        data_ok_i,
    input  logic [31:0] rdata_i,
    input  logic        hit_i,
    input  logic        rd_req_i,
    input  logic        wr_req_i,
    input  logic        wr_rdy_i,
    input  paddr_t      wr_addr_i,
    input  cache_line_u wr_data_i,
    output int          tests_o,
    output int          errors_o
);
    logic [7:0]  cmem [logic [31:0]];  // bytes written by the cpu
    logic        s2_v;
    logic        s2_rd;
    logic        s2_fetch;
    logic        s2_chk;
    logic        s2_seen;  // rd_req_o seen for this request
    logic [95:0] s2_name;
    logic [31:0] s2_exp;

    function automatic logic [7:0] model_byte(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00} ^ 32'h5a5a0000;
        return cmem.exists(a) ? cmem[a] : w[8*a[1:0] +: 8];
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return {model_byte(a + 32'd3), model_byte(a + 32'd2),
                model_byte(a + 32'd1), model_byte(a)};
    endfunction

    task automatic finish_row(input logic seen);
        logic ok;
        ok = 1'b1;
        if (s2_chk && seen != s2_fetch) begin
            $display("mismatch %0s fetch expected %0d actual %0d", s2_name, s2_fetch, seen);
            ok = 1'b0;
        end
        if (s2_chk && hit_i !== !s2_fetch) begin
            $display("mismatch %0s hit expected %0d actual %0d", s2_name, !s2_fetch, hit_i);
            ok = 1'b0;
        end
        if (s2_rd && !data_ok_i) begin
            $display("load %0s finished without returning data", s2_name);
            ok = 1'b0;
        end else if (s2_rd && rdata_i !== s2_exp) begin
            $display("mismatch %0s expected %h actual %h", s2_name, s2_exp, rdata_i);
            ok = 1'b0;
        end else if (!s2_rd && data_ok_i) begin
            $display("store %0s returned load data", s2_name);
            ok = 1'b0;
        end
        tests_o++;
        if (ok) $display("%0s passed", s2_name);
        else errors_o++;
    endtask

    task automatic check_writeback();
        cache_line_u want;
        for (int w = 0; w < 4; w++) begin
            want.words[w] = model_word(wr_addr_i + 32'(4*w));
        end
        if (wr_data_i.raw !== want.raw) begin
            $display("mismatch writeback %h expected %h actual %h",
                     wr_addr_i, want.raw, wr_data_i.raw);
            errors_o++;
        end
    endtask

    //////////////////////////////////////////////////
    // follow the stage 2 request
    //////////////////////////////////////////////////
    always @(posedge clk) begin : watch
        logic seen;
        seen = s2_seen | rd_req_i;
        if (!rst) begin
            s2_v     = 1'b0;
            s2_seen  = 1'b0;
            tests_o  = 0;
            errors_o = 0;
        end else begin
            if (wr_req_i && wr_rdy_i) check_writeback();
            if (stall_i) begin
                s2_seen = seen;
            end else begin
                if (s2_v) finish_row(seen);
                s2_v     = req_i.rvalid | req_i.wvalid;
                s2_rd    = req_i.rvalid;
                s2_fetch = fetch_i;
                s2_chk   = chk_i;
                s2_name  = name_i;
                s2_seen  = 1'b0;
                if (req_i.wvalid) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.wsel[b]) begin
                            cmem[{req_i.addr[31:2], 2'b00} + 32'(b)] = req_i.wdata[8*b +: 8];
                        end
                    end
                end
                s2_exp = chk_i ? exp_i : model_word({req_i.addr[31:2], 2'b00});
            end
        end
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache import dcache_pkg::*; ();
    typedef struct packed {
        logic [95:0] name;
        logic        wr;
        logic [31:0] addr;
        logic [3:0]  wsel;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic        fetch;
        logic        chk;     // 0: checker predicts from its model
    } row_t;

    logic                  clk;
    logic                  rst;
    cpu_req_t              req_i;
    logic                  ret_valid_i;
    cache_line_u           ret_data_i;
    logic                  wr_rdy_i;
    logic                  stall_o;
    logic                  data_ok_o;
    logic [`DC_WORD_W-1:0] rdata_o;
    logic                  hit_o;
    logic                  rd_req_o;
    paddr_t                rd_addr_o;
    logic                  wr_req_o;
    paddr_t                wr_addr_o;
    cache_line_u           wr_data_o;

    logic [95:0] cur_name;
    logic [31:0] cur_exp;
    logic        cur_fetch;
    logic        cur_chk;
    int          tests;
    int          errors;

    row_t        rows[$];
    logic [7:0]  mem [logic [31:0]];  // sparse backing store
    logic [31:0] lfsr;
    int          rd_wait;
    int          wr_wait;

    dcache_top dut0 (.*);

    tb_dcache_checker chk0 (
        .clk(clk), .rst(rst), .req_i(req_i),
        .name_i(cur_name), .exp_i(cur_exp), .fetch_i(cur_fetch), .chk_i(cur_chk),
        .stall_i(stall_o), .data_ok_i(data_ok_o), .rdata_i(rdata_o), .hit_i(hit_o),
        .rd_req_i(rd_req_o), .wr_req_i(wr_req_o), .wr_rdy_i(wr_rdy_i),
        .wr_addr_i(wr_addr_o), .wr_data_i(wr_data_o),
        .tests_o(tests), .errors_o(errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic cache_line_u read_line(input logic [31:0] a);
        cache_line_u l;
        logic [31:0] b;
        logic [31:0] w;
        for (int k = 0; k < 16; k++) begin
            b = a + 32'(k);
            w = {b[31:2], 2'b00} ^ 32'h5a5a0000;  // untouched memory
            l.raw[8*k +: 8] = mem.exists(b) ? mem[b] : w[8*b[1:0] +: 8];
        end
        return l;
    endfunction

    task automatic add_row(input logic [95:0] name, input logic wr, input logic [31:0] addr,
                           input logic [3:0] wsel, input logic [31:0] wdata,
                           input logic [31:0] exp, input logic fetch, input logic chk);
        rows.push_back('{name, wr, addr, wsel, wdata, exp, fetch, chk});
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("Errors found");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////
    always @(negedge clk) begin : mem_model
        logic rq;
        logic wq;
        rq          = rd_req_o;
        wq          = wr_req_o;
        ret_valid_i = 1'b0;
        wr_rdy_i    = 1'b0;
        if (rq) begin
            if (rd_wait == 0) rd_wait = 2 + int'(rand_bits(2));  // first edge only arms it
            rd_wait--;
            if (rd_wait == 0) begin
                ret_data_i  = read_line(rd_addr_o);
                ret_valid_i = 1'b1;
            end
        end
        if (wq) begin
            if (wr_wait == 0) wr_wait = 2 + int'(rand_bits(2));
            wr_wait--;
            if (wr_wait == 0) begin
                for (int k = 0; k < 16; k++) begin
                    mem[wr_addr_o + 32'(k)] = wr_data_o.raw[8*k +: 8];
                end
                wr_rdy_i = 1'b1;
            end
        end
    end

    task automatic apply_row(input int i);
        int t;
        @(negedge clk);
        req_i.rvalid = !rows[i].wr;
        req_i.wvalid = rows[i].wr;
        req_i.addr   = rows[i].addr;
        req_i.wsel   = rows[i].wsel;
        req_i.wdata  = rows[i].wdata;
        cur_name     = rows[i].name;
        cur_exp      = rows[i].exp;
        cur_fetch    = rows[i].fetch;
        cur_chk      = rows[i].chk;
        #1;
        t = 0;
        while (stall_o) begin  // held until the cache takes it
            @(negedge clk);
            #1;
            t++;
            if (t > 200) give_up($sformatf("stall_o stayed high at row %0d", i));
        end
    endtask

    initial begin : main
        logic [31:0] idx;
        logic [31:0] tag;
        logic [3:0]  ws;
        int          t;
        lfsr      = 32'h4a7d61fe;
        rst       = 1'b0;
        req_i     = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        wr_rdy_i  = 1'b0;
        cur_name  = '0;
        cur_exp   = '0;
        cur_fetch = 1'b0;
        cur_chk   = 1'b0;
        rd_wait   = 0;
        wr_wait   = 0;

        add_row("cold_miss",   0, 32'h00001010, 4'h0, 32'h0, 32'h5a5a1010, 1, 1);
        add_row("line_hit",    0, 32'h00001014, 4'h0, 32'h0, 32'h5a5a1014, 0, 1);
        add_row("store_hit",   1, 32'h00001018, 4'h3, 32'hdeadbeef, 32'h0, 0, 1);
        add_row("fwd_load",    0, 32'h00001018, 4'h0, 32'h0, 32'h5a5abeef, 0, 1);
        add_row("store_miss",  1, 32'h00002024, 4'hf, 32'h12345678, 32'h0, 1, 1);
        add_row("alloc_word",  0, 32'h00002024, 4'h0, 32'h0, 32'h12345678, 0, 1);
        add_row("alloc_rest",  0, 32'h00002028, 4'h0, 32'h0, 32'h5a5a2028, 0, 1);
        add_row("wb_store_a",  1, 32'h00010050, 4'hf, 32'ha5a5a5a5, 32'h0, 1, 1);
        add_row("wb_load_b",   0, 32'h00011054, 4'h0, 32'h0, 32'h5a5b1054, 1, 1);
        add_row("wb_load_c",   0, 32'h00012058, 4'h0, 32'h0, 32'h5a5b2058, 1, 1);
        add_row("wb_reload_a", 0, 32'h00010050, 4'h0, 32'h0, 32'ha5a5a5a5, 1, 1);
        add_row("lru_a",       0, 32'h00020070, 4'h0, 32'h0, 32'h5a580070, 1, 1);
        add_row("lru_b",       0, 32'h00021070, 4'h0, 32'h0, 32'h5a581070, 1, 1);
        add_row("lru_a_hit",   0, 32'h00020070, 4'h0, 32'h0, 32'h5a580070, 0, 1);
        add_row("lru_c",       0, 32'h00022070, 4'h0, 32'h0, 32'h5a582070, 1, 1);
        add_row("lru_a_kept",  0, 32'h00020070, 4'h0, 32'h0, 32'h5a580070, 0, 1);
        add_row("lru_b_gone",  0, 32'h00021070, 4'h0, 32'h0, 32'h5a581070, 1, 1);
        for (int n = 0; n < 40; n++) begin  // sets 8..11, tags 0x30..0x32
            idx = 32'd8 + rand_bits(2);
            tag = 32'h30 + (rand_bits(2) % 3);
            ws  = 4'(rand_bits(4));
            add_row("random", rand_bits(1) != 0,
                    {tag[19:0], idx[7:0], 2'(rand_bits(2)), 2'b00},
                    (ws == 4'h0) ? 4'hf : ws, rand_bits(32), 32'h0, 0, 0);
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < rows.size(); i++) apply_row(i);

        @(negedge clk);
        req_i = '0;
        #1;
        t = 0;
        while (stall_o) begin
            @(negedge clk);
            #1;
            t++;
            if (t > 200) give_up("last request never completed");
        end
        repeat (3) @(negedge clk);

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_checker.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -f compile.f

out=$(./obj_dir/Vtb_dcache)
echo "$out"
echo "$out" | grep -q "^No errors$"
